/* flist.f */
exe_pkg.sv
exe_alu.sv
exe_mul_unit.sv
exe_div_unit.sv
exe_muldiv_seq.sv
exe_stage.sv
tb_exe_stage.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_exe_stage
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := No errors

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and look for the pass message"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* tb_exe_stage.sv */
`timescale 1ns/10ps

module tb_exe_stage import exe_pkg::*; ();

    localparam int WAIT_LIMIT = 60;                           // in cycles and well past one op

    logic     clk;
    logic     i_arst_n;
    logic     i_valid;
    exe_req_t i_req;
    logic     o_mem_valid;
    exe_mem_t o_mem;
    logic     o_branch_taken;
    addr_t    o_branch_target;
    logic     o_calc_stall;

    int   seed;
    iid_t tag;
    int   errors;
    int   test_errors;
    int   checks;
    int   tests;

    exe_stage i_dut (
        .clk             (clk),
        .i_arst_n        (i_arst_n),
        .i_valid         (i_valid),
        .i_req           (i_req),
        .o_mem_valid     (o_mem_valid),
        .o_mem           (o_mem),
        .o_branch_taken  (o_branch_taken),
        .o_branch_target (o_branch_target),
        .o_calc_stall    (o_calc_stall)
    );

    always #5 clk = ~clk;

    function automatic word_t rnd();
        return word_t'($random(seed));
    endfunction

    function automatic word_t alu_model(alu_sel_e sel, logic sgn, word_t a, word_t b);
        case (sel)
            ALU_ADD:   return a + b;
            ALU_SUB:   return a - b;
            ALU_SLL:   return a << b[4:0];
            ALU_SRL:   return a >> b[4:0];
            ALU_SRA:   return word_t'($signed(a) >>> b[4:0]);
            ALU_AND:   return a & b;
            ALU_OR:    return a | b;
            ALU_XOR:   return a ^ b;
            ALU_SLT:   return (sgn ? ($signed(a) < $signed(b)) : (a < b)) ? 32'd1 : 32'd0;
            ALU_SLTU:  return (a < b) ? 32'd1 : 32'd0;
            ALU_COPY1: return a;
            default:   return '0;
        endcase
    endfunction

    function automatic logic br_model(br_sel_e br, word_t a, word_t b);
        case (br)
            BR_EQ:   return a == b;
            BR_NE:   return a != b;
            BR_LT:   return $signed(a) < $signed(b);
            BR_GE:   return $signed(a) >= $signed(b);
            BR_LTU:  return a < b;
            BR_GEU:  return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    // high or low word of the full 64-bit product
    function automatic word_t mul_model(alu_sel_e sel, logic sgn, word_t a, word_t b);
        logic [63:0] ea;
        logic [63:0] eb;
        logic [63:0] p;
        ea = sgn ? {{32{a[31]}}, a} : {32'b0, a};
        eb = (sgn && sel != ALU_MULHSU) ? {{32{b[31]}}, b} : {32'b0, b};
        p  = ea * eb;
        return (sel == ALU_MUL) ? p[31:0] : p[63:32];
    endfunction

    function automatic word_t div_model(alu_sel_e sel, logic sgn, word_t a, word_t b);
        longint na;
        longint nb;
        longint q;
        longint r;
        if (b == '0) begin
            return (sel == ALU_DIV) ? 32'hffff_ffff : a;       // x/0 is -1 and x%0 is x
        end
        na = sgn ? longint'($signed(a)) : longint'({32'b0, a});
        nb = sgn ? longint'($signed(b)) : longint'({32'b0, b});
        q  = na / nb;                                          // min / -1 gives 2^31 with min low
        r  = na % nb;
        return (sel == ALU_DIV) ? word_t'(q) : word_t'(r);
    endfunction

    task automatic flag_error(input string msg);
        $display("ERR %0t %s", $time, msg);
        errors++;
        test_errors++;
    endtask

    task automatic finish_test(input string name);
        tests++;
        $display("%s finished with %0d errors", name, test_errors);
        test_errors = 0;
    endtask

    task automatic build_req(input alu_sel_e sel, input br_sel_e br, input logic sgn,
                             input logic jpc, input logic jreg, input word_t a, input word_t b,
                             output exe_req_t r);
        r.pc               = rnd() & 32'hffff_fffc;
        r.inst             = rnd();
        r.inst_id          = tag;
        r.ctrl.alu_sel     = sel;
        r.ctrl.br_sel      = br;
        r.ctrl.sign_sel    = sgn;
        r.ctrl.jmp_pc_flg  = jpc;
        r.ctrl.jmp_reg_flg = jreg;
        r.imm_b            = rnd();
        r.imm_j            = rnd();
        r.op1              = a;
        r.op2              = b;
        r.rs2              = rnd();
        tag                = tag + 4'd1;                       // wraps at 16
    endtask

    task automatic present(input logic v, input exe_req_t r);
        @(posedge clk);
        i_valid <= v;
        i_req   <= r;
    endtask

    task automatic await_result(output int cycles);
        cycles = 0;
        @(negedge clk);
        while (!o_mem_valid && cycles < WAIT_LIMIT) begin
            if (!o_calc_stall) begin
                flag_error("o_calc_stall low while no result");
            end
            @(negedge clk);
            cycles++;
        end
        if (!o_mem_valid) begin
            $display("timeout: o_mem_valid did not rise within %0d cycles", WAIT_LIMIT);
            errors++;
            test_errors++;
        end
    endtask

    task automatic run_muldiv(input alu_sel_e sel, input logic sgn, input word_t a,
                              input word_t b, input string name);
        exe_req_t r;
        word_t    exp;
        int       cycles;
        exp = (sel == ALU_DIV || sel == ALU_REM) ? div_model(sel, sgn, a, b)
                                                 : mul_model(sel, sgn, a, b);
        build_req(sel, BR_NONE, sgn, 1'b0, 1'b0, a, b, r);
        present(1'b1, r);
        await_result(cycles);
        checks++;
        if (cycles != MULDIV_STEPS + 1) begin
            flag_error($sformatf("%s stalled %0d cycles", name, cycles));
        end
        if (o_mem.alu_out !== exp) begin
            flag_error($sformatf("%s %h, %h gave %h, expected %h",
                                 name, a, b, o_mem.alu_out, exp));
        end
    endtask

    task automatic after_reset();
        @(negedge clk);
        checks++;
        if (o_calc_stall || o_mem_valid || o_branch_taken) begin
            flag_error("outputs not idle after reset");
        end
        finish_test("reset");
    endtask

    task automatic alu_ops();
        alu_sel_e sels [11] = '{ALU_ADD, ALU_SUB, ALU_SLL, ALU_SRL, ALU_SRA, ALU_AND,
                                ALU_OR, ALU_XOR, ALU_SLT, ALU_SLTU, ALU_COPY1};
        exe_req_t r;
        word_t    exp;
        for (int i = 0; i < 11; i++) begin
            for (int k = 0; k < 4; k++) begin
                build_req(sels[i], BR_NONE, k[0], 1'b0, 1'b0, rnd(), rnd(), r);
                present(1'b1, r);
                @(negedge clk);
                exp = alu_model(sels[i], r.ctrl.sign_sel, r.op1, r.op2);
                checks++;
                if (!o_mem_valid || o_calc_stall) begin
                    flag_error($sformatf("%s not single cycle", sels[i].name()));
                end
                if (o_mem.alu_out !== exp) begin
                    flag_error($sformatf("%s gave %h, expected %h",
                                         sels[i].name(), o_mem.alu_out, exp));
                end
                if (o_mem.pc !== r.pc || o_mem.inst !== r.inst ||
                    o_mem.inst_id !== r.inst_id || o_mem.ctrl !== r.ctrl ||
                    o_mem.rs2 !== r.rs2) begin
                    flag_error("pass-through fields differ");
                end
            end
        end
        finish_test("alu");
    endtask

    task automatic branch_ops();
        br_sel_e  brs [7] = '{BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU};
        word_t    lhs [5] = '{32'd5, 32'hffff_fffd, 32'd7, 32'd2, 32'd9};
        word_t    rhs [5] = '{32'd5, 32'd7, 32'hffff_fffd, 32'd9, 32'd2};
        exe_req_t r;
        for (int i = 0; i < 7; i++) begin
            for (int k = 0; k < 5; k++) begin
                build_req(ALU_ADD, brs[i], 1'b0, 1'b0, 1'b0, lhs[k], rhs[k], r);
                present(1'b1, r);
                @(negedge clk);
                checks++;
                if (o_branch_taken !== br_model(brs[i], lhs[k], rhs[k])) begin
                    flag_error($sformatf("%s on %h, %h gave taken %b",
                                         brs[i].name(), lhs[k], rhs[k], o_branch_taken));
                end
                if (o_branch_target !== r.pc + r.imm_b) begin
                    flag_error($sformatf("branch target %h is wrong", o_branch_target));
                end
            end
        end
        build_req(ALU_ADD, BR_NONE, 1'b0, 1'b1, 1'b0, rnd(), rnd(), r);
        present(1'b1, r);
        @(negedge clk);
        checks++;
        if (!o_branch_taken || o_branch_target !== r.pc + r.imm_j) begin
            flag_error($sformatf("jal gave taken %b target %h", o_branch_taken, o_branch_target));
        end
        build_req(ALU_ADD, BR_NONE, 1'b0, 1'b0, 1'b1, rnd(), rnd(), r);
        present(1'b1, r);
        @(negedge clk);
        checks++;
        if (!o_branch_taken || o_branch_target !== r.op1 + r.op2) begin
            flag_error($sformatf("jalr gave taken %b target %h", o_branch_taken, o_branch_target));
        end
        build_req(ALU_ADD, BR_EQ, 1'b0, 1'b1, 1'b0, 32'd3, 32'd3, r);
        present(1'b0, r);
        @(negedge clk);
        checks++;
        if (o_branch_taken || o_mem_valid) begin
            flag_error("branch taken with i_valid low");
        end
        finish_test("branch");
    endtask

    task automatic multiply_ops();
        word_t lhs [6] = '{32'd0, 32'hffff_ffff, 32'h8000_0000, 32'h8000_0000,
                           32'h7fff_ffff, 32'd12345};
        word_t rhs [6] = '{32'h1234_5678, 32'hffff_ffff, 32'h8000_0000, 32'hffff_ffff,
                           32'h8000_0000, 32'd0};
        word_t a;
        word_t b;
        for (int k = 0; k < 10; k++) begin
            if (k < 6) begin
                a = lhs[k];
                b = rhs[k];
            end else begin
                a = rnd();
                b = rnd();
            end
            run_muldiv(ALU_MUL,    1'b1, a, b, "mul");
            run_muldiv(ALU_MULH,   1'b1, a, b, "mulh");
            run_muldiv(ALU_MULH,   1'b0, a, b, "mulhu");
            run_muldiv(ALU_MULHSU, 1'b1, a, b, "mulhsu");
        end
        finish_test("multiply");
    endtask

    task automatic divide_ops();
        word_t lhs [5] = '{32'h1357_9bdf, 32'h8000_0000, 32'hffff_fff9, 32'd7, 32'd0};
        word_t rhs [5] = '{32'd0, 32'hffff_ffff, 32'd2, 32'hffff_fffe, 32'd5};
        word_t a;
        word_t b;
        for (int k = 0; k < 10; k++) begin
            if (k < 5) begin
                a = lhs[k];
                b = rhs[k];
            end else begin
                a = rnd();
                b = rnd() >> (k * 3);                          // spread of divisor sizes
            end
            run_muldiv(ALU_DIV, 1'b1, a, b, "div");
            run_muldiv(ALU_DIV, 1'b0, a, b, "divu");
            run_muldiv(ALU_REM, 1'b1, a, b, "rem");
            run_muldiv(ALU_REM, 1'b0, a, b, "remu");
        end
        finish_test("divide");
    endtask

    task automatic sequencing();
        exe_req_t r;
        word_t    a;
        word_t    b;
        word_t    held;
        run_muldiv(ALU_MULH, 1'b1, rnd(), rnd(), "first of pair");
        a = rnd();
        b = rnd();
        run_muldiv(ALU_REM,  1'b1, a, b, "second of pair");
        held = div_model(ALU_REM, 1'b1, a, b);
        for (int k = 0; k < 5; k++) begin
            @(negedge clk);
            checks++;
            if (!o_mem_valid || o_calc_stall || o_mem.alu_out !== held) begin
                flag_error("result not held while the same tag stays");
            end
        end
        build_req(ALU_DIV, BR_NONE, 1'b1, 1'b0, 1'b0, rnd(), rnd(), r);
        present(1'b1, r);
        repeat (10) @(posedge clk);                            // mid BUSY
        present(1'b0, r);
        @(negedge clk);
        checks++;
        if (o_calc_stall || o_mem_valid) begin
            flag_error("stall or valid with i_valid low");
        end
        run_muldiv(ALU_MUL, 1'b1, rnd(), rnd(), "after abandon");
        finish_test("sequencing");
    endtask

    initial begin
        seed        = 32'hbeb6;
        tag         = '0;
        errors      = 0;
        test_errors = 0;
        checks      = 0;
        tests       = 0;
        clk         = 1'b0;
        i_arst_n    = 1'b0;
        i_valid     = 1'b0;
        i_req       = '0;
        repeat (4) @(posedge clk);
        i_arst_n <= 1'b1;
        after_reset();
        alu_ops();
        branch_ops();
        multiply_ops();
        divide_ops();
        sequencing();
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

/* exe_stage.sv */
`timescale 1ns/10ps

module exe_stage import exe_pkg::*; (
    input  logic     clk,
    input  logic     i_arst_n,

    input  logic     i_valid,
    input  exe_req_t i_req,

    output logic     o_mem_valid,
    output exe_mem_t o_mem,

    output logic     o_branch_taken,
    output addr_t    o_branch_target,

    output logic     o_calc_stall
);

    ctrl_t ctrl;
    word_t alu_result;
    word_t md_result;
    logic  alu_branch_take;
    logic  md_stall;

    assign ctrl = i_req.ctrl;

    exe_alu u_alu (
        .i_alu_sel     (ctrl.alu_sel),
        .i_br_sel      (ctrl.br_sel),
        .i_sign_sel    (ctrl.sign_sel),
        .i_op1         (i_req.op1),
        .i_op2         (i_req.op2),
        .o_result      (alu_result),
        .o_branch_take (alu_branch_take)
    );

    exe_muldiv_seq u_seq (
        .clk        (clk),
        .i_arst_n   (i_arst_n),
        .i_valid    (i_valid),
        .i_inst_id  (i_req.inst_id),
        .i_alu_sel  (ctrl.alu_sel),
        .i_sign_sel (ctrl.sign_sel),
        .i_op1      (i_req.op1),
        .i_op2      (i_req.op2),
        .o_stall    (md_stall),
        .o_result   (md_result)
    );

    assign o_calc_stall = md_stall;
    assign o_mem_valid  = i_valid && !md_stall;

    always_comb begin
        o_mem.pc      = i_req.pc;
        o_mem.inst    = i_req.inst;
        o_mem.inst_id = i_req.inst_id;
        o_mem.ctrl    = ctrl;
        o_mem.alu_out = is_muldiv(ctrl.alu_sel) ? md_result : alu_result;
        o_mem.rs2     = i_req.rs2;
    end

    assign o_branch_taken = i_valid &&
                            (ctrl.jmp_pc_flg || ctrl.jmp_reg_flg || alu_branch_take);

    always_comb begin
        if (ctrl.jmp_pc_flg) begin
            o_branch_target = i_req.pc + i_req.imm_j;         // jal
        end else if (ctrl.jmp_reg_flg) begin
            o_branch_target = i_req.op1 + i_req.op2;          // jalr, op2 carries imm
        end else begin
            o_branch_target = i_req.pc + i_req.imm_b;
        end
    end

endmodule

/* exe_muldiv_seq.sv */
`timescale 1ns/10ps

module exe_muldiv_seq import exe_pkg::*; (
    input  logic     clk,
    input  logic     i_arst_n,
    input  logic     i_valid,
    input  iid_t     i_inst_id,
    input  alu_sel_e i_alu_sel,
    input  logic     i_sign_sel,
    input  word_t    i_op1,
    input  word_t    i_op2,
    output logic     o_stall,
    output word_t    o_result
);

    typedef enum logic [1:0] {ST_IDLE, ST_BUSY, ST_DONE} state_e;

    state_e                        state_q;
    state_e                        state_d;
    logic [MULDIV_CNT_W-1:0]       step_cnt_q;
    iid_t                          saved_id_q;
    logic                          saved_vld_q;
    alu_sel_e                      op_q;                      // op being computed
    logic                          is_mul;
    logic                          is_div;
    logic                          op_is_mul;
    logic                          same_tag;
    logic                          start;
    logic                          stepping;
    logic                          last_step;
    logic [MULDIV_WIDTH-1:0]       op1_ext;
    logic [MULDIV_WIDTH-1:0]       op2_ext;
    logic [MULDIV_WIDTH-1:0]       mplier_ext;
    logic [2*MULDIV_WIDTH-1:0]     product;
    logic [MULDIV_WIDTH-1:0]       quotient;
    logic [MULDIV_WIDTH-1:0]       remainder;

    assign is_mul    = i_alu_sel inside {ALU_MUL, ALU_MULH, ALU_MULHSU};
    assign is_div    = i_alu_sel inside {ALU_DIV, ALU_REM};
    assign op_is_mul = op_q inside {ALU_MUL, ALU_MULH, ALU_MULHSU};
    assign same_tag  = saved_vld_q && (saved_id_q == i_inst_id);
    assign start     = i_valid && (is_mul || is_div) &&
                       ((state_q == ST_IDLE) || ((state_q == ST_DONE) && !same_tag));
    assign stepping  = (state_q == ST_BUSY) && i_valid;       // valid drop abandons the op
    assign last_step = stepping && (step_cnt_q == MULDIV_CNT_W'(MULDIV_STEPS - 1));
    assign o_stall   = i_valid && (is_mul || is_div) && ((state_q == ST_BUSY) || start);

    assign op1_ext    = i_sign_sel ? {i_op1[31], i_op1} : {1'b0, i_op1};
    assign op2_ext    = i_sign_sel ? {i_op2[31], i_op2} : {1'b0, i_op2};
    assign mplier_ext = (i_alu_sel == ALU_MULHSU) ? {1'b0, i_op2} : op2_ext;

    exe_mul_unit u_mul (
        .clk            (clk),
        .i_arst_n       (i_arst_n),
        .i_load         (start && is_mul),
        .i_step         (stepping && op_is_mul),
        .i_multiplicand (op1_ext),
        .i_multiplier   (mplier_ext),
        .o_product      (product)
    );

    exe_div_unit u_div (
        .clk         (clk),
        .i_arst_n    (i_arst_n),
        .i_load      (start && is_div),
        .i_step      (stepping && !op_is_mul),
        .i_signed    (i_sign_sel),
        .i_dividend  (op1_ext),
        .i_divisor   (op2_ext),
        .o_quotient  (quotient),
        .o_remainder (remainder)
    );

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: if (start) state_d = ST_BUSY;
            ST_BUSY: begin
                if (!i_valid) begin
                    state_d = ST_IDLE;
                end else if (last_step) begin
                    state_d = ST_DONE;
                end
            end
            ST_DONE: begin
                if (start) begin
                    state_d = ST_BUSY;                        // next op starts at once
                end else if (!i_valid || !(is_mul || is_div)) begin
                    state_d = ST_IDLE;
                end
            end
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state_q     <= ST_IDLE;
            step_cnt_q  <= '0;
            saved_id_q  <= '0;
            saved_vld_q <= 1'b0;
            op_q        <= ALU_ADD;
        end else begin
            state_q <= state_d;
            if (start) begin
                step_cnt_q <= '0;
                op_q       <= i_alu_sel;
            end else if (stepping) begin
                step_cnt_q <= step_cnt_q + 1'b1;
            end
            if (last_step) begin
                saved_id_q  <= i_inst_id;
                saved_vld_q <= 1'b1;
            end else if (start || (state_d == ST_IDLE)) begin
                saved_vld_q <= 1'b0;
            end
        end
    end

    // units sit idle in DONE, so their outputs hold the result
    always_comb begin
        o_result = '0;
        if (state_q == ST_DONE) begin
            case (op_q)
                ALU_MUL:              o_result = product[31:0];
                ALU_MULH, ALU_MULHSU: o_result = product[63:32];
                ALU_DIV:              o_result = quotient[31:0];
                ALU_REM:              o_result = remainder[31:0];
                default:              o_result = '0;
            endcase
        end
    end

    a_done_result_held: assert property (@(posedge clk) disable iff (!i_arst_n)
        (state_q == ST_DONE) && (state_d == ST_DONE) |=> $stable(o_result));

    a_cnt_range: assert property (@(posedge clk) disable iff (!i_arst_n)
        (state_q != ST_BUSY) |-> (step_cnt_q <= MULDIV_CNT_W'(MULDIV_STEPS)));

endmodule

/* exe_div_unit.sv */
`timescale 1ns/10ps

module exe_div_unit import exe_pkg::*; (
    input  logic                    clk,
    input  logic                    i_arst_n,
    input  logic                    i_load,
    input  logic                    i_step,
    input  logic                    i_signed,
    input  logic [MULDIV_WIDTH-1:0] i_dividend,
    input  logic [MULDIV_WIDTH-1:0] i_divisor,
    output logic [MULDIV_WIDTH-1:0] o_quotient,
    output logic [MULDIV_WIDTH-1:0] o_remainder
);

    localparam int W = MULDIV_WIDTH;

    logic [W-1:0] dvd_mag;
    logic [W-1:0] dvs_mag;
    logic [W-1:0] dvs_q;
    logic [W-1:0] quo_q;                                      // dividend bits out, quotient bits in
    logic [W-1:0] rem_q;
    logic         q_neg_q;
    logic         r_neg_q;
    logic         dz_q;                                       // divide by zero
    logic [W:0]   shifted;
    logic [W:0]   diff;
    logic         ge;

    assign dvd_mag = (i_signed && i_dividend[W-1]) ? -i_dividend : i_dividend;
    assign dvs_mag = (i_signed && i_divisor[W-1])  ? -i_divisor  : i_divisor;

    assign shifted = {rem_q, quo_q[W-1]};
    assign diff    = shifted - {1'b0, dvs_q};
    assign ge      = (shifted >= {1'b0, dvs_q});

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            q_neg_q <= 1'b0;
            r_neg_q <= 1'b0;
            dz_q    <= 1'b0;
        end else if (i_load) begin
            q_neg_q <= i_signed && (i_dividend[W-1] ^ i_divisor[W-1]);
            r_neg_q <= i_signed && i_dividend[W-1];           // remainder follows dividend
            dz_q    <= (i_divisor == '0);
        end
    end

    always_ff @(posedge clk) begin
        if (i_load) begin
            dvs_q <= dvs_mag;
            quo_q <= dvd_mag;
            rem_q <= '0;
        end else if (i_step) begin
            rem_q <= ge ? diff[W-1:0] : shifted[W-1:0];       // restore on borrow
            quo_q <= {quo_q[W-2:0], ge};
        end
    end

    // riscv: x/0 = -1, x%0 = x
    assign o_quotient  = dz_q ? '1 : (q_neg_q ? -quo_q : quo_q);
    assign o_remainder = r_neg_q ? -rem_q : rem_q;

    a_load_step_excl: assert property (@(posedge clk) disable iff (!i_arst_n)
        !(i_load && i_step));

endmodule

/* exe_mul_unit.sv */
`timescale 1ns/10ps

module exe_mul_unit import exe_pkg::*; (
    input  logic                        clk,
    input  logic                        i_arst_n,
    input  logic                        i_load,
    input  logic                        i_step,
    input  logic [MULDIV_WIDTH-1:0]     i_multiplicand,
    input  logic [MULDIV_WIDTH-1:0]     i_multiplier,
    output logic [2*MULDIV_WIDTH-1:0]   o_product
);

    localparam int W = MULDIV_WIDTH;

    logic [W-1:0] mcand_q;
    logic [W:0]   acc_q;                                      // extra bit keeps partial sums exact
    logic [W-1:0] mplier_q;
    logic [W-1:0] mark_q;                                     // one-hot, marks the sign-bit step
    logic [W:0]   addend;
    logic [W:0]   sum;

    always_comb begin
        addend = '0;
        if (mplier_q[0]) begin
            // multiplier msb weighs -2^(W-1)
            addend = mark_q[W-1] ? -{mcand_q[W-1], mcand_q} : {mcand_q[W-1], mcand_q};
        end
        sum = acc_q + addend;
    end

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            mark_q <= '0;
        end else if (i_load) begin
            mark_q <= W'(1);
        end else if (i_step) begin
            mark_q <= mark_q << 1;
        end
    end

    always_ff @(posedge clk) begin
        if (i_load) begin
            mcand_q  <= i_multiplicand;
            mplier_q <= i_multiplier;
            acc_q    <= '0;
        end else if (i_step) begin
            {acc_q, mplier_q} <= {sum[W], sum, mplier_q[W-1:1]};  // arithmetic shift
        end
    end

    assign o_product = {acc_q[W-1:0], mplier_q};

    a_load_step_excl: assert property (@(posedge clk) disable iff (!i_arst_n)
        !(i_load && i_step));

endmodule

/* exe_alu.sv */
`timescale 1ns/10ps

module exe_alu import exe_pkg::*; (
    input  alu_sel_e i_alu_sel,
    input  br_sel_e  i_br_sel,
    input  logic     i_sign_sel,
    input  word_t    i_op1,
    input  word_t    i_op2,
    output word_t    o_result,
    output logic     o_branch_take
);

    logic [4:0] shamt;
    logic       eq;
    logic       lt_s;
    logic       lt_u;

    assign shamt = i_op2[4:0];
    assign eq    = (i_op1 == i_op2);
    assign lt_s  = ($signed(i_op1) < $signed(i_op2));
    assign lt_u  = (i_op1 < i_op2);

    always_comb begin
        case (i_alu_sel)
            ALU_ADD:   o_result = i_op1 + i_op2;
            ALU_SUB:   o_result = i_op1 - i_op2;
            ALU_SLL:   o_result = i_op1 << shamt;
            ALU_SRL:   o_result = i_op1 >> shamt;
            ALU_SRA:   o_result = $signed(i_op1) >>> shamt;
            ALU_AND:   o_result = i_op1 & i_op2;
            ALU_OR:    o_result = i_op1 | i_op2;
            ALU_XOR:   o_result = i_op1 ^ i_op2;
            ALU_SLT:   o_result = {31'b0, (i_sign_sel ? lt_s : lt_u)};  // decode sets sign_sel
            ALU_SLTU:  o_result = {31'b0, lt_u};
            ALU_COPY1: o_result = i_op1;                                 // lui path
            default:   o_result = '0;                                    // mul/div in sequencer
        endcase
    end

    always_comb begin
        case (i_br_sel)
            BR_EQ:   o_branch_take = eq;
            BR_NE:   o_branch_take = !eq;
            BR_LT:   o_branch_take = lt_s;
            BR_GE:   o_branch_take = !lt_s;
            BR_LTU:  o_branch_take = lt_u;
            BR_GEU:  o_branch_take = !lt_u;
            default: o_branch_take = 1'b0;
        endcase
    end

endmodule

/* exe_pkg.sv */
package exe_pkg;

    localparam int WORD_W       = 32;
    localparam int IID_W        = 4;
    localparam int MULDIV_WIDTH = 33;                         // one guard bit over the word
    localparam int MULDIV_STEPS = 33;                         // one iteration per operand bit
    localparam int MULDIV_CNT_W = $clog2(MULDIV_STEPS + 1);

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [WORD_W-1:0] addr_t;
    typedef logic [WORD_W-1:0] inst_t;
    typedef logic [IID_W-1:0]  iid_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_COPY1,
        ALU_MUL,
        ALU_MULH,
        ALU_MULHSU,
        ALU_DIV,
        ALU_REM
    } alu_sel_e;

    typedef enum logic [2:0] {
        BR_NONE,
        BR_EQ,
        BR_NE,
        BR_LT,
        BR_GE,
        BR_LTU,
        BR_GEU
    } br_sel_e;

    typedef struct packed {
        alu_sel_e alu_sel;
        br_sel_e  br_sel;
        logic     sign_sel;                                   // signed mul/div/slt
        logic     jmp_pc_flg;                                 // jal
        logic     jmp_reg_flg;                                // jalr
    } ctrl_t;

    typedef struct packed {
        addr_t pc;
        inst_t inst;
        iid_t  inst_id;
        ctrl_t ctrl;
        word_t imm_b;
        word_t imm_j;
        word_t op1;
        word_t op2;
        word_t rs2;
    } exe_req_t;

    typedef struct packed {
        addr_t pc;
        inst_t inst;
        iid_t  inst_id;
        ctrl_t ctrl;
        word_t alu_out;
        word_t rs2;
    } exe_mem_t;

    // ops that go through the iterative units
    function automatic logic is_muldiv(alu_sel_e sel);
        return sel inside {ALU_MUL, ALU_MULH, ALU_MULHSU, ALU_DIV, ALU_REM};
    endfunction

endpackage
